/* files.f */
+incdir+source
source/uartBusPkg.sv
source/uartLinkPkg.sv
source/syncFifo.sv
source/uartRx.sv
source/uartTx.sv
source/uartRegs.sv
source/uartPeriph.sv
testbench/uartChecker.sv
testbench/uartPeriphTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= uartPeriphTb
RTL_TOP ?= uartPeriph
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/uartPeriphTb.sv */
`timescale 1ns/10ps
`include "uart_params.svh"
`default_nettype none

module uartPeriphTb;

	import uartBusPkg::*;

	logic clk;
	logic rstN;
	apbReq apbIn;
	apbRsp apbOut;
	logic uartRxLine;
	logic uartTxLine;
	logic uartEn;
	int checkErrors;
	logic modelIdle;
	int tbErrors;
	integer seed;
	int cpb;

	uartPeriph i_dut (
		.clk(clk), .rstN(rstN), .apbIn(apbIn), .apbOut(apbOut),
		.uartRx(uartRxLine), .uartTx(uartTxLine), .uartEn(uartEn)
	);

	uartChecker checkUnit (
		.clk(clk), .rstN(rstN), .req(apbIn), .rsp(apbOut), .txLine(uartTxLine),
		.rxLine(uartRxLine), .uartEn(uartEn), .errorCount(checkErrors), .modelIdle(modelIdle)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic finishRun();
		$display("errors: checker %0d, testbench %0d", checkErrors, tbErrors);
		if (checkErrors == 0 && tbErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timeout: %s", what);
		tbErrors++;
		finishRun();
	endtask

	task automatic apbXfer(input logic write, input logic [11:0] addr,
		input logic [31:0] data, input logic [3:0] strb);
		int waited;
		waited = 0;
		@(negedge clk);
		apbIn.sel = 1'b1;
		apbIn.enable = 1'b0;
		apbIn.write = write;
		apbIn.addr = addr;
		apbIn.wdata = data;
		apbIn.strb = strb;
		@(negedge clk);
		apbIn.enable = 1'b1;
		#1;
		while (!apbOut.ready) begin
			waited++;
			if (waited > 5000)
				abortOnTimeout("pready stayed low");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		apbIn.sel = 1'b0;
		apbIn.enable = 1'b0;
	endtask

	task automatic setCfg(input logic en, input logic waitMode);
		apbXfer(1'b1, `UART_ADDR_CFG, {14'b0, en, waitMode, 16'(cpb)}, 4'b0111);
	endtask

	task automatic sendFrame(input logic [7:0] data, input logic badStop);
		logic [9:0] bits;
		bits = {!badStop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			uartRxLine = bits[i];
			repeat (cpb) @(negedge clk);
		end
		@(negedge clk);
		uartRxLine = 1'b1;
		repeat (3 * (cpb + 1)) @(negedge clk);
	endtask

	task automatic waitTxDrain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!modelIdle) begin
			waited++;
			if (waited > 100000)
				abortOnTimeout("transmit queue never drained");
			@(negedge clk);
		end
	endtask

	initial begin
		int n;
		seed = 32'h777bd6b3;
		tbErrors = 0;
		apbIn = '0;
		uartRxLine = 1'b1;
		rstN = 1'b0;
		cpb = 3;
		repeat (5) @(negedge clk);
		rstN = 1'b1;

		apbXfer(1'b0, `UART_ADDR_CFG, 32'b0, 4'b0);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		apbXfer(1'b0, `UART_ADDR_RXDATA, 32'b0, 4'b0);

		// transmit path
		cpb = 3 + $unsigned($random(seed)) % 7;
		setCfg(1'b1, 1'b0);
		n = 8 + $unsigned($random(seed)) % 8;
		repeat (n) begin
			apbXfer(1'b1, `UART_ADDR_TXDATA, $random(seed), 4'b0001);
			apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		end
		waitTxDrain();

		// receive path with some frames ending in a low stop bit
		cpb = 3 + $unsigned($random(seed)) % 7;
		setCfg(1'b1, 1'b0);
		repeat (8) sendFrame(8'($random(seed)), ($random(seed) & 3) == 0);
		repeat (9) apbXfer(1'b0, `UART_ADDR_RXDATA, 32'b0, 4'b0);

		// rx overflow and read back of the 32 frames that fit
		repeat (33) sendFrame(8'($random(seed)), 1'b0);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		repeat (33) apbXfer(1'b0, `UART_ADDR_RXDATA, 32'b0, 4'b0);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		apbXfer(1'b1, `UART_ADDR_CLEAR, 32'h4, 4'b0001);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);

		// tx overflow while disabled
		setCfg(1'b0, 1'b0);
		repeat (33) apbXfer(1'b1, `UART_ADDR_TXDATA, $random(seed), 4'b0001);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);

		// wait mode refills the freed slot and then stalls on the next write
		setCfg(1'b1, 1'b1);
		apbXfer(1'b1, `UART_ADDR_TXDATA, $random(seed), 4'b0001);
		apbXfer(1'b1, `UART_ADDR_TXDATA, $random(seed), 4'b0001);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		waitTxDrain();
		apbXfer(1'b1, `UART_ADDR_CLEAR, 32'h8, 4'b0001);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);

		// clears and unmapped addresses
		setCfg(1'b1, 1'b0);
		repeat (2) sendFrame(8'($random(seed)), 1'b0);
		setCfg(1'b0, 1'b0);
		repeat (3) apbXfer(1'b1, `UART_ADDR_TXDATA, $random(seed), 4'b0001);
		apbXfer(1'b1, `UART_ADDR_CLEAR, 32'hf, 4'b0000);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		apbXfer(1'b1, `UART_ADDR_CLEAR, 32'hc, 4'b0001);
		apbXfer(1'b0, `UART_ADDR_STATUS, 32'b0, 4'b0);
		apbXfer(1'b0, `UART_ADDR_RXDATA, 32'b0, 4'b0);
		apbXfer(1'b0, 12'h00c, 32'b0, 4'b0);
		apbXfer(1'b0, 12'h018, 32'b0, 4'b0);
		apbXfer(1'b0, 12'h7fc, 32'b0, 4'b0);
		apbXfer(1'b1, 12'h00c, 32'h1234, 4'b1111);
		apbXfer(1'b1, `UART_ADDR_CFG, 32'h0003_1234, 4'b0001);
		apbXfer(1'b0, `UART_ADDR_CFG, 32'b0, 4'b0);
		apbXfer(1'b1, `UART_ADDR_CLEAR, 32'h3, 4'b0001);
		repeat (4) @(negedge clk);
		finishRun();
	end

endmodule

`default_nettype wire

/* testbench/uartChecker.sv */
`timescale 1ns/10ps
`include "uart_params.svh"
`default_nettype none

module uartChecker (
	input logic clk,
	input logic rstN,
	input uartBusPkg::apbReq req,
	input uartBusPkg::apbRsp rsp,
	input logic txLine,
	input logic rxLine,
	input logic uartEn,
	output int errorCount,
	output logic modelIdle
);

	import uartBusPkg::*;
	import uartLinkPkg::*;

	uartCfg cfgM;
	logic [7:0] txQ[$];
	logic [7:0] outQ[$];
	rxEntry rxQ[$];
	logic txLost;
	logic rxLost;
	int busyCnt;
	int errs = 0;
	logic txDecOn;
	int txDecCnt;
	int txDecBit;
	logic [7:0] txDecShift;
	logic txLast;
	logic rxDecOn;
	int rxDecCnt;
	int rxDecBit;
	logic [7:0] rxDecShift;
	logic rxLast;

	assign errorCount = errs;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errs++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic reportError(input string what);
		errs++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	always @(posedge clk) begin
		uartStatus expStatus;
		rxEntry entry;
		logic [31:0] expData;
		logic [7:0] expByte;
		logic access;
		logic done;
		logic mapped;
		logic popNow;
		logic txFullPre;
		logic stallExp;
		int p;
		if (!rstN) begin
			cfgM = `UART_CFG_RESET;
			txQ.delete();
			outQ.delete();
			rxQ.delete();
			txLost = 1'b0;
			rxLost = 1'b0;
			busyCnt = 0;
			txDecOn = 1'b0;
			rxDecOn = 1'b0;
			txLast = 1'b1;
			rxLast = 1'b1;
		end else begin
			p = int'(cfgM.cyclesPerBit) + 1;
			compare("uartEn", uartEn, cfgM.enable);
			// snapshot of the state before this edge
			expStatus.txDataLost = txLost;
			expStatus.txBufferFull = (txQ.size() == `UART_FIFO_DEPTH);
			expStatus.txByteOutAvailable = (txQ.size() > 0);
			expStatus.rxDataLost = rxLost;
			expStatus.rxBufferFull = (rxQ.size() == `UART_FIFO_DEPTH);
			expStatus.rxDataAvailable = (rxQ.size() > 0);
			access = req.sel && req.enable;
			mapped = req.addr inside {`UART_ADDR_CFG, `UART_ADDR_CLEAR, `UART_ADDR_STATUS,
				`UART_ADDR_RXDATA, `UART_ADDR_TXDATA};
			txFullPre = (txQ.size() == `UART_FIFO_DEPTH);
			stallExp = access && req.write && req.addr == `UART_ADDR_TXDATA
				&& cfgM.waitForTxSpace && cfgM.enable && txFullPre;
			popNow = busyCnt == 0 && cfgM.enable && txQ.size() > 0;
			if (access) begin
				compare("pready", rsp.ready, !stallExp);
				if (rsp.ready)
					compare("pslverr", rsp.slverr, !mapped);
			end
			done = access && !stallExp;

			if (done && !req.write) begin
				case (req.addr)
					`UART_ADDR_CFG: expData = {14'b0, cfgM};
					`UART_ADDR_STATUS: expData = {26'b0, expStatus};
					`UART_ADDR_RXDATA: begin
						if (rxQ.size() > 0)
							expData = {22'b0, 1'b1, rxQ.pop_front()};
						else
							expData = 32'b0;
					end
					`UART_ADDR_CLEAR, `UART_ADDR_TXDATA: expData = 32'b0;
					default: expData = '1;
				endcase
				compare("prdata", rsp.rdata, expData);
			end

			// tx engine: one frame lasts ten bit periods
			if (busyCnt > 0) begin
				busyCnt--;
			end else if (popNow) begin
				outQ.push_back(txQ.pop_front());
				busyCnt = 10 * p;
			end

			if (done && req.write) begin
				case (req.addr)
					`UART_ADDR_CFG: begin
						if (req.strb[0])
							cfgM.cyclesPerBit[7:0] = req.wdata[7:0];
						if (req.strb[1])
							cfgM.cyclesPerBit[15:8] = req.wdata[15:8];
						if (req.strb[2]) begin
							cfgM.waitForTxSpace = req.wdata[16];
							cfgM.enable = req.wdata[17];
						end
					end
					`UART_ADDR_CLEAR: begin
						if (req.strb[0]) begin
							if (req.wdata[0])
								rxDecOn = 1'b0;
							if (req.wdata[1]) begin
								busyCnt = 0;
								outQ.delete();
								txDecOn = 1'b0;
							end
							if (req.wdata[2]) begin
								rxQ.delete();
								rxLost = 1'b0;
							end
							if (req.wdata[3]) begin
								txQ.delete();
								txLost = 1'b0;
							end
						end
					end
					`UART_ADDR_TXDATA: begin
						if (req.strb[0]) begin
							if (!txFullPre)
								txQ.push_back(req.wdata[7:0]);
							else if (!cfgM.waitForTxSpace)
								txLost = 1'b1;
						end
					end
					default: ;
				endcase
			end

			// decode uartTx at mid-bit
			if (txDecOn) begin
				if (txDecCnt > 0) begin
					txDecCnt--;
				end else if (txDecBit < 8) begin
					txDecShift = {txLine, txDecShift[7:1]};
					txDecBit++;
					txDecCnt = p - 1;
				end else begin
					txDecOn = 1'b0;
					if (!txLine)
						reportError("stop bit low on uartTx");
					if (outQ.size() == 0) begin
						reportError("frame on uartTx with no byte written");
					end else begin
						expByte = outQ.pop_front();
						compare("uartTx byte", txDecShift, expByte);
					end
				end
			end else if (txLast && !txLine) begin
				txDecOn = 1'b1;
				txDecCnt = p + p / 2 - 2;
				txDecBit = 0;
			end
			txLast = txLine;

			// same decoder on uartRx, feeds the rx FIFO model
			if (rxDecOn) begin
				if (rxDecCnt > 0) begin
					rxDecCnt--;
				end else if (rxDecBit < 8) begin
					rxDecShift = {rxLine, rxDecShift[7:1]};
					rxDecBit++;
					rxDecCnt = p - 1;
				end else begin
					rxDecOn = 1'b0;
					entry.data = rxDecShift;
					entry.frameError = !rxLine;
					if (rxQ.size() == `UART_FIFO_DEPTH)
						rxLost = 1'b1;
					else
						rxQ.push_back(entry);
				end
			end else if (cfgM.enable && rxLast && !rxLine) begin
				rxDecOn = 1'b1;
				rxDecCnt = p + p / 2 - 2;
				rxDecBit = 0;
			end
			rxLast = rxLine;
		end
		modelIdle = txQ.size() == 0 && outQ.size() == 0 && busyCnt == 0 && !txDecOn;
	end

endmodule

`default_nettype wire

/* source/uartPeriph.sv */
`timescale 1ns/10ps
`include "uart_params.svh"
`default_nettype none

module uartPeriph (
	input logic clk,
	input logic rstN,
	input uartBusPkg::apbReq apbIn,
	output uartBusPkg::apbRsp apbOut,
	input logic uartRx,
	output logic uartTx,
	output logic uartEn
);

	import uartBusPkg::*;
	import uartLinkPkg::*;

	uartCfg cfg;
	fifoFlags txFlags;
	fifoFlags rxFlags;
	rxEntry rxHead;
	rxEntry rxIn;
	logic rxValid;
	logic rxPush;
	logic rxPop;
	logic txPush;
	logic txPop;
	logic txReady;
	logic [7:0] txData;
	logic [7:0] txHead;
	logic clrRx;
	logic clrTx;
	logic clrRxFifo;
	logic clrTxFifo;

	assign uartEn = cfg.enable;
	assign txPop = txFlags.notEmpty && txReady;

	uartRegs regs (
		.clk(clk), .rstN(rstN), .req(apbIn), .rsp(apbOut), .cfg(cfg),
		.txPush(txPush), .txData(txData), .txFlags(txFlags),
		.rxPop(rxPop), .rxHead(rxHead), .rxFlags(rxFlags),
		.rxValid(rxValid), .rxPush(rxPush),
		.clrRx(clrRx), .clrTx(clrTx), .clrRxFifo(clrRxFifo), .clrTxFifo(clrTxFifo)
	);

	uartRx rxEngine (
		.clk(clk), .rstN(rstN), .clear(clrRx), .cfg(cfg),
		.rxLine(uartRx), .valid(rxValid), .entry(rxIn)
	);

	uartTx txEngine (
		.clk(clk), .rstN(rstN), .clear(clrTx), .cfg(cfg),
		.valid(txPop), .data(txHead), .ready(txReady), .txLine(uartTx)
	);

	syncFifo #(.payloadT(rxEntry), .DEPTH(`UART_FIFO_DEPTH)) rxFifo (
		.clk(clk), .rstN(rstN), .clear(clrRxFifo),
		.push(rxPush), .din(rxIn), .pop(rxPop), .dout(rxHead), .flags(rxFlags)
	);

	syncFifo #(.payloadT(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) txFifo (
		.clk(clk), .rstN(rstN), .clear(clrTxFifo),
		.push(txPush), .din(txData), .pop(txPop), .dout(txHead), .flags(txFlags)
	);

endmodule

`default_nettype wire

/* source/uartRegs.sv */
`timescale 1ns/10ps
`include "uart_params.svh"
`default_nettype none

module uartRegs (
	input logic clk,
	input logic rstN,
	input uartBusPkg::apbReq req,
	output uartBusPkg::apbRsp rsp,
	output uartBusPkg::uartCfg cfg,
	output logic txPush,
	output logic [7:0] txData,
	input uartLinkPkg::fifoFlags txFlags,
	output logic rxPop,
	input uartLinkPkg::rxEntry rxHead,
	input uartLinkPkg::fifoFlags rxFlags,
	input logic rxValid,
	output logic rxPush,
	output logic clrRx,
	output logic clrTx,
	output logic clrRxFifo,
	output logic clrTxFifo
);

	import uartBusPkg::*;

	uartCfg cfgQ;
	uartStatus status;
	logic access;
	logic done;
	logic wrDone;
	logic rdDone;
	logic hitCfg;
	logic hitClear;
	logic hitStatus;
	logic hitRxData;
	logic hitTxData;
	logic mapped;
	logic txStall;
	logic clrWrite;
	logic [31:0] rxWord;

	assign hitCfg = (req.addr == `UART_ADDR_CFG);
	assign hitClear = (req.addr == `UART_ADDR_CLEAR);
	assign hitStatus = (req.addr == `UART_ADDR_STATUS);
	assign hitRxData = (req.addr == `UART_ADDR_RXDATA);
	assign hitTxData = (req.addr == `UART_ADDR_TXDATA);
	assign mapped = hitCfg || hitClear || hitStatus || hitRxData || hitTxData;

	assign access = req.sel && req.enable;

	// wait mode stalls the bus instead of dropping the byte
	assign txStall = hitTxData && req.write && cfgQ.waitForTxSpace && cfgQ.enable
		&& txFlags.full;

	assign done = access && !txStall;
	assign wrDone = done && req.write;
	assign rdDone = done && !req.write;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cfgQ <= `UART_CFG_RESET;
		end else if (wrDone && hitCfg) begin
			if (req.strb[0])
				cfgQ.cyclesPerBit[7:0] <= req.wdata[7:0];
			if (req.strb[1])
				cfgQ.cyclesPerBit[15:8] <= req.wdata[15:8];
			if (req.strb[2]) begin
				cfgQ.waitForTxSpace <= req.wdata[16];
				cfgQ.enable <= req.wdata[17];
			end
		end
	end

	assign cfg = cfgQ;

	// clear strobes last for the completing cycle only
	assign clrWrite = wrDone && hitClear && req.strb[0];
	assign clrRx = clrWrite && req.wdata[0];
	assign clrTx = clrWrite && req.wdata[1];
	assign clrRxFifo = clrWrite && req.wdata[2];
	assign clrTxFifo = clrWrite && req.wdata[3];

	// full FIFO in wait mode holds the byte back, otherwise FIFO counts it as lost
	assign txPush = wrDone && hitTxData && req.strb[0]
		&& !(cfgQ.waitForTxSpace && txFlags.full);
	assign txData = req.wdata[7:0];

	assign rxPop = rdDone && hitRxData;
	assign rxPush = rxValid && cfgQ.enable;

	assign status.txDataLost = txFlags.lost;
	assign status.txBufferFull = txFlags.full;
	assign status.txByteOutAvailable = txFlags.notEmpty;
	assign status.rxDataLost = rxFlags.lost;
	assign status.rxBufferFull = rxFlags.full;
	assign status.rxDataAvailable = rxFlags.notEmpty;

	// bit 9 marks a valid entry
	assign rxWord = rxFlags.notEmpty ? {22'b0, 1'b1, rxHead} : 32'b0;

	always_comb begin
		rsp.ready = done;
		rsp.slverr = access && !mapped;
		if (hitCfg)
			rsp.rdata = {14'b0, cfgQ};
		else if (hitStatus)
			rsp.rdata = {26'b0, status};
		else if (hitRxData)
			rsp.rdata = rxWord;
		else if (hitClear || hitTxData)
			rsp.rdata = 32'b0;
		else
			rsp.rdata = '1;
	end

endmodule

`default_nettype wire

/* source/uartTx.sv */
`timescale 1ns/10ps
`default_nettype none

module uartTx (
	input logic clk,
	input logic rstN,
	input logic clear,
	input uartBusPkg::uartCfg cfg,
	input logic valid,
	input logic [7:0] data,
	output logic ready,
	output logic txLine
);

	logic busy;
	logic [15:0] cnt;
	logic [3:0] bitIdx;
	logic [8:0] shiftReg;
	logic bitEnd;
	logic accept;

	assign ready = !busy && cfg.enable;
	assign accept = valid && ready;
	assign bitEnd = (cnt == 16'd0);

	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			busy <= 1'b0;
			txLine <= 1'b1;
			cnt <= '0;
			bitIdx <= '0;
		end else if (!busy) begin
			if (accept) begin
				// start bit goes out right away
				busy <= 1'b1;
				txLine <= 1'b0;
				cnt <= cfg.cyclesPerBit;
				bitIdx <= '0;
			end
		end else if (bitEnd) begin
			if (bitIdx == 4'd9) begin
				// stop bit done, line already high
				busy <= 1'b0;
			end else begin
				txLine <= shiftReg[0];
				cnt <= cfg.cyclesPerBit;
				bitIdx <= bitIdx + 1'b1;
			end
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// data bits with the stop bit queued behind them
	always_ff @(posedge clk) begin
		if (!busy && accept)
			shiftReg <= {1'b1, data};
		else if (busy && bitEnd)
			shiftReg <= {1'b1, shiftReg[8:1]};
	end

endmodule

`default_nettype wire

/* source/uartRx.sv */
`timescale 1ns/10ps
`default_nettype none

module uartRx (
	input logic clk,
	input logic rstN,
	input logic clear,
	input uartBusPkg::uartCfg cfg,
	input logic rxLine,
	output logic valid,
	output uartLinkPkg::rxEntry entry
);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxState;

	rxState state;
	logic rxMeta;
	logic rxSync;
	logic lineQ;
	logic line;
	logic [15:0] cnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic sampleNow;

	// disabled port looks like an idle line
	assign line = cfg.enable ? rxSync : 1'b1;
	assign sampleNow = (cnt == 16'd0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= rxLine;
			rxSync <= rxMeta;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			state <= IDLE;
			lineQ <= 1'b1;
			cnt <= '0;
			bitIdx <= '0;
			valid <= 1'b0;
		end else begin
			lineQ <= line;
			valid <= 1'b0;
			case (state)
				IDLE: begin
					// falling edge, wait half a bit
					if (lineQ && !line) begin
						state <= START;
						cnt <= cfg.cyclesPerBit >> 1;
					end
				end
				START: begin
					if (sampleNow) begin
						if (!line) begin
							state <= DATA;
							cnt <= cfg.cyclesPerBit;
							bitIdx <= '0;
						end else begin
							state <= IDLE;
						end
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				DATA: begin
					if (sampleNow) begin
						cnt <= cfg.cyclesPerBit;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= STOP;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				STOP: begin
					if (sampleNow) begin
						valid <= 1'b1;
						state <= IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == DATA && sampleNow)
			shiftReg <= {line, shiftReg[7:1]};
		if (state == STOP && sampleNow) begin
			entry.data <= shiftReg;
			entry.frameError <= !line;
		end
	end

endmodule

`default_nettype wire

/* source/syncFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module syncFifo #(
	parameter type payloadT = logic [7:0],
	parameter int DEPTH = 32
) (
	input logic clk,
	input logic rstN,
	input logic clear,
	input logic push,
	input payloadT din,
	input logic pop,
	output payloadT dout,
	output uartLinkPkg::fifoFlags flags
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payloadT mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic lost;
	logic full;
	logic notEmpty;
	logic doPush;
	logic doPop;

	assign full = (count == CNT_W'(DEPTH));
	assign notEmpty = (count != '0);
	assign doPush = push && !full;
	assign doPop = pop && notEmpty;

	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			lost <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// overflow stays flagged until cleared
			if (push && full)
				lost <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	assign dout = mem[rdPtr];

	assign flags.notEmpty = notEmpty;
	assign flags.full = full;
	assign flags.lost = lost;

endmodule

`default_nettype wire

/* source/uartLinkPkg.sv */
`default_nettype none

package uartLinkPkg;

	// one received frame as stored in the rx FIFO
	// frameError sits just above the data byte
	typedef struct packed {
		logic frameError;
		logic [7:0] data;
	} rxEntry;

	// occupancy flags of one FIFO
	// lost is sticky until the FIFO is cleared
	typedef struct packed {
		logic lost;
		logic full;
		logic notEmpty;
	} fifoFlags;

endpackage

`default_nettype wire

/* source/uartBusPkg.sv */
`default_nettype none

package uartBusPkg;

	// master side of an APB transfer
	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [11:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
	} apbReq;

	// slave side
	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
		logic slverr;
	} apbRsp;

	// config word, bit 17 down to bit 0
	typedef struct packed {
		logic enable;
		logic waitForTxSpace;
		logic [15:0] cyclesPerBit;
	} uartCfg;

	// status word, rx flags in the low bits
	typedef struct packed {
		logic txDataLost;
		logic txBufferFull;
		logic txByteOutAvailable;
		logic rxDataLost;
		logic rxBufferFull;
		logic rxDataAvailable;
	} uartStatus;

endpackage

`default_nettype wire

/* source/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// entries per FIFO, shared by rx and tx
`define UART_FIFO_DEPTH 32

// config after reset: disabled, no wait mode, bit period 0x1047
// 0x1047 gives roughly 9600 baud from a 40 MHz clock
`define UART_CFG_RESET 18'h01047

// register byte offsets within the peripheral window
`define UART_ADDR_CFG 12'h000

`define UART_ADDR_CLEAR 12'h004

`define UART_ADDR_STATUS 12'h008

// 0x00c is a hole
`define UART_ADDR_RXDATA 12'h010

`define UART_ADDR_TXDATA 12'h014

`endif
